// File: hdl/ov5640_init_table.svh
`ifndef OV5640_INIT_TABLE_SVH
`define OV5640_INIT_TABLE_SVH

// Power-up register writes for the OV5640, {addr[15:0], value[7:0]} per entry
// Clock, reset, power-down, PLL and analog front end setup
localparam reg_entry_t INIT_TABLE [0:REG_NUM-1] = '{
    24'h3103_11,    // Sysclk taken from pad
    24'h3008_82,    // Software reset
    24'h3008_42,    // Enter software power down
    24'h3103_03,    // Sysclk switched to PLL
    24'h3017_ff,    // Frex, vsync, href, pclk, d[9:6] drivers on
    24'h3018_ff,    // D[5:0] and gpio drivers on
    24'h3034_1a,    // MIPI 10 bit mode
    24'h3037_13,    // PLL root and pre divider
    24'h3108_01,    // Pclk and sclk root dividers
    24'h3630_36,
    24'h3631_0e,
    24'h3632_e2,
    24'h3633_12,
    24'h3621_e0,
    24'h3704_a0,
    24'h3703_5a,
    24'h3715_78,
    24'h3717_01,
    24'h370b_60,
    24'h3705_1a,
    24'h3905_02,
    24'h3906_10,
    24'h3901_0a,
    24'h3731_12,
    24'h3600_08,    // VCM setup
    24'h3601_33,
    24'h302d_60,    // System control
    24'h3620_52,
    24'h371b_20,
    24'h471c_50,
    24'h3a13_43,    // AEC pre-gain
    24'h3a18_00     // Gain ceiling high byte
};

`endif

// File: hdl/cmos_cfg_pkg.sv
`default_nettype none

package cmos_cfg_pkg;

    typedef logic [7:0]  byte_t;        // One SCCB byte
    typedef logic [15:0] reg_addr_t;    // Sensor register address
    typedef logic [23:0] reg_entry_t;   // {addr, value}
    typedef logic [3:0]  cmd_t;         // Byte master command bits

    // Bit 2 would be the read command, never used here
    localparam cmd_t CMD_START = 4'b0001;
    localparam cmd_t CMD_WRITE = 4'b0010;
    localparam cmd_t CMD_STOP  = 4'b1000;

    localparam byte_t SCCB_WRITE_ID = 8'h78;    // OV5640 write address

    localparam int REG_NUM = 32;

    typedef logic [$clog2(REG_NUM)-1:0] reg_idx_t;
    typedef logic [1:0]                 byte_phase_t;   // ID, addr hi, addr lo, data

    typedef enum logic [1:0] {
        WAIT_POWER,     // Sensor power-up window
        IDLE,
        ISSUE,          // Request one byte
        WAIT_BYTE       // Byte in flight on the bus
    } cfg_state_t;

    `include "ov5640_init_table.svh"

endpackage

`default_nettype wire

// File: hdl/power_up_timer.sv
`timescale 1ns/1ps
`default_nettype none

module power_up_timer #(
    parameter int POWER_UP_CYCLES = 1_000_000   // 20 ms at 50 MHz
) (
    input  logic clk,
    input  logic rst_n,
    output logic expired
);

    localparam int CNT_W = (POWER_UP_CYCLES > 1) ? $clog2(POWER_UP_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(POWER_UP_CYCLES - 1);

    logic [CNT_W-1:0] cnt;

    // Counts once after reset, then parks on the terminal value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt != CNT_LAST) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign expired = (cnt == CNT_LAST);    // Stays high once reached

endmodule

`default_nettype wire

// File: hdl/sccb_byte_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sccb_byte_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue,
    input  logic                byte_ack,
    output logic                frame_last,
    output logic                table_last,
    output logic                req,
    output cmos_cfg_pkg::cmd_t  cmd,
    output cmos_cfg_pkg::byte_t dout
);

    import cmos_cfg_pkg::*;

    localparam reg_idx_t LAST_IDX = reg_idx_t'(REG_NUM - 1);

    reg_idx_t    idx;
    byte_phase_t phase;
    reg_entry_t  entry;
    reg_addr_t   entry_addr;
    byte_t       entry_val;
    cmd_t        cmd_nxt;
    byte_t       dout_nxt;

    assign entry      = INIT_TABLE[idx];
    assign entry_addr = entry[23:8];
    assign entry_val  = entry[7:0];

    assign frame_last = (phase == 2'd3);
    assign table_last = (idx == LAST_IDX);

    // Position in the table, moves on each acknowledged byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
            idx   <= '0;
        end else if (byte_ack) begin
            if (frame_last) begin
                phase <= '0;
                if (!table_last) begin
                    idx <= idx + 1'b1;     // Last entry holds its index
                end
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // Framing of one register write
    always_comb begin
        case (phase)
            2'd0: begin
                cmd_nxt  = CMD_START | CMD_WRITE;
                dout_nxt = SCCB_WRITE_ID;
            end
            2'd1: begin
                cmd_nxt  = CMD_WRITE;
                dout_nxt = entry_addr[15:8];
            end
            2'd2: begin
                cmd_nxt  = CMD_WRITE;
                dout_nxt = entry_addr[7:0];
            end
            default: begin
                cmd_nxt  = CMD_STOP | CMD_WRITE;
                dout_nxt = entry_val;
            end
        endcase
    end

    // One-cycle command, zero otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req  <= 1'b0;
            cmd  <= '0;
            dout <= '0;
        end else if (issue) begin
            req  <= 1'b1;
            cmd  <= cmd_nxt;
            dout <= dout_nxt;
        end else begin
            req  <= 1'b0;
            cmd  <= '0;
            dout <= '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cmos_config_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cmos_config_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic expired,
    input  logic done,
    input  logic frame_last,
    input  logic table_last,
    output logic issue,
    output logic byte_ack,
    output logic config_done
);

    import cmos_cfg_pkg::*;

    cfg_state_t state;
    cfg_state_t state_nxt;
    logic       table_end;

    assign issue     = (state == ISSUE);
    assign byte_ack  = (state == WAIT_BYTE) && done;   // Stray done ignored
    assign table_end = byte_ack && frame_last && table_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= WAIT_POWER;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            WAIT_POWER: begin
                if (expired) begin
                    state_nxt = IDLE;
                end
            end
            IDLE: begin
                if (!config_done) begin
                    state_nxt = ISSUE;     // Parked here for good once done
                end
            end
            ISSUE: begin
                state_nxt = WAIT_BYTE;
            end
            WAIT_BYTE: begin
                if (byte_ack) begin
                    // Entry boundary goes back through IDLE
                    state_nxt = frame_last ? IDLE : ISSUE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            config_done <= 1'b0;
        end else if (table_end) begin
            config_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cmos_config.sv
`timescale 1ns/1ps
`default_nettype none

module cmos_config #(
    parameter int POWER_UP_CYCLES = 1_000_000
) (
    input  logic                clk,
    input  logic                rst_n,
    output logic                req,
    output cmos_cfg_pkg::cmd_t  cmd,
    output cmos_cfg_pkg::byte_t dout,
    input  logic                done,
    output logic                config_done
);

    logic expired;
    logic issue;
    logic byte_ack;
    logic frame_last;
    logic table_last;

    power_up_timer #(
        .POWER_UP_CYCLES (POWER_UP_CYCLES)
    ) u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .expired (expired)
    );

    cmos_config_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .expired     (expired),
        .done        (done),
        .frame_last  (frame_last),
        .table_last  (table_last),
        .issue       (issue),
        .byte_ack    (byte_ack),
        .config_done (config_done)
    );

    sccb_byte_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (issue),
        .byte_ack   (byte_ack),
        .frame_last (frame_last),
        .table_last (table_last),
        .req        (req),
        .cmd        (cmd),
        .dout       (dout)
    );

endmodule

`default_nettype wire

// File: verification/cmos_config_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cmos_config_sva (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire logic                req,
    input wire cmos_cfg_pkg::cmd_t  cmd,
    input wire cmos_cfg_pkg::byte_t dout,
    input wire logic                config_done
);

    // Request is a single-cycle pulse
    req_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) req |=> !req)
        else $error("req held high on two consecutive cycles");

    // Command bus idles at zero
    bus_zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !req |-> (cmd == '0 && dout == '0))
        else $error("cmd or dout nonzero while req is low");

    // Silent once configured
    no_req_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        config_done |-> !req)
        else $error("req issued after config_done");

endmodule

bind cmos_config cmos_config_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .cmd         (cmd),
    .dout        (dout),
    .config_done (config_done)
);

`default_nettype wire

// File: verification/cmos_config_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cmos_config_tb;

    import cmos_cfg_pkg::*;

    localparam int POWER_UP_CYCLES = 200;
    localparam int TOTAL_BYTES     = REG_NUM * 4;
    localparam int WATCHDOG_CYCLES = POWER_UP_CYCLES + TOTAL_BYTES * 20 + 500 + 200;

    logic  clk;
    logic  rst_n;
    logic  req;
    cmd_t  cmd;
    byte_t dout;
    logic  done;
    logic  config_done;

    int cyc            = 0;     // Edges since reset release
    int n_bytes        = 0;     // Requests captured
    int final_done_cyc = -1;
    int outstanding    = 0;
    int done_seen      = 0;
    int errs [1:5];
    int tests_passed   = 0;
    int tests_failed   = 0;

    cmos_config #(
        .POWER_UP_CYCLES (POWER_UP_CYCLES)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .cmd         (cmd),
        .dout        (dout),
        .done        (done),
        .config_done (config_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period
    end

    // Expected {cmd, dout} for one byte of a register write
    function automatic logic [11:0] expected_byte(input int entry_idx, input int ph);
        reg_entry_t e;
        e = INIT_TABLE[entry_idx];
        case (ph)
            0:       return {CMD_START | CMD_WRITE, SCCB_WRITE_ID};
            1:       return {CMD_WRITE, e[23:16]};
            2:       return {CMD_WRITE, e[15:8]};
            default: return {CMD_STOP | CMD_WRITE, e[7:0]};
        endcase
    endfunction

    task automatic report_test(input string name, input int n_err);
        if (n_err == 0) begin
            $display("%-20s ok", name);
            tests_passed++;
        end else begin
            $display("%-20s failed with %0d errors", name, n_err);
            tests_failed++;
        end
    endtask

    // Byte master model, random gap before each done
    initial begin : byte_master
        int unsigned gap;
        forever begin
            @(posedge clk);
            #1;
            if (req) begin
                gap = $urandom % 16;
                repeat (gap + 1) begin    // Idle cycles follow the req cycle
                    @(posedge clk);
                    #1;
                end
                done = 1'b1;
                @(posedge clk);
                #1;
                done = 1'b0;
            end
        end
    end

    // Capture and compare on the falling edge
    always @(negedge clk) begin : compare_bytes
        logic [11:0] exp;
        if (rst_n) begin
            if (cyc <= POWER_UP_CYCLES && (req || config_done)) begin
                $display("Activity during the power-up wait at cycle %0d", cyc);
                errs[1]++;
            end
            if (req) begin
                if (config_done) begin
                    $display("Request issued after config_done at cycle %0d", cyc);
                    errs[5]++;
                end
                if (outstanding != 0) begin
                    $display("Request at cycle %0d while a byte still waits for done", cyc);
                    errs[3]++;
                end
                if (n_bytes >= TOTAL_BYTES) begin
                    $display("More requests than table bytes at cycle %0d", cyc);
                    errs[4]++;
                end else begin
                    exp = expected_byte(n_bytes / 4, n_bytes % 4);
                    if ({cmd, dout} !== exp) begin
                        $display("Mismatch in byte_sequence byte %0d: expected %h/%h, actual %h/%h",
                                 n_bytes, exp[11:8], exp[7:0], cmd, dout);
                        errs[2]++;
                    end
                end
                n_bytes++;
                outstanding = 1;
            end
            if (done) begin
                outstanding = 0;
                if (n_bytes == TOTAL_BYTES) begin
                    final_done_cyc = cyc;    // Last byte acknowledged
                end
            end
            if (config_done && done_seen == 0) begin
                done_seen = 1;
                if (final_done_cyc < 0 || cyc != final_done_cyc + 1) begin
                    $display("Mismatch in completion: config_done expected at cycle %0d, actual %0d",
                             final_done_cyc + 1, cyc);
                    errs[4]++;
                end
            end else if (done_seen != 0 && !config_done) begin
                $display("config_done dropped at cycle %0d", cyc);
                errs[4]++;
            end
            cyc++;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        int total;
        void'($urandom(32'h0b92_39b9));
        for (int i = 1; i <= 5; i++) begin
            errs[i] = 0;
        end
        rst_n = 1'b0;
        done  = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        repeat (POWER_UP_CYCLES + 1) @(posedge clk);
        report_test("power_up_quiet", errs[1]);

        while (!config_done) @(posedge clk);    // Watchdog bounds this wait
        @(posedge clk);
        if (n_bytes != TOTAL_BYTES) begin
            $display("Mismatch in byte_sequence: byte count expected %0d, actual %0d",
                     TOTAL_BYTES, n_bytes);
            errs[2]++;
        end
        report_test("byte_sequence", errs[2]);
        report_test("single_outstanding", errs[3]);

        repeat (500) @(posedge clk);    // Quiet period after completion
        if (n_bytes != TOTAL_BYTES) begin
            $display("Mismatch in completion: request count expected %0d, actual %0d",
                     TOTAL_BYTES, n_bytes);
            errs[4]++;
        end
        report_test("completion", errs[4]);
        report_test("post_done_silence", errs[5]);

        total = errs[1] + errs[2] + errs[3] + errs[4] + errs[5];
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d bytes checked, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, n_bytes, total);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/cmos_cfg_pkg.sv
hdl/power_up_timer.sv
hdl/sccb_byte_sequencer.sv
hdl/cmos_config_ctrl.sv
hdl/cmos_config.sv
verification/cmos_config_sva.sv
verification/cmos_config_tb.sv

// File: Makefile
SIM := obj_dir/Vcmos_config_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module cmos_config_tb -f files.f

run: compile
	./$(SIM) | tee /dev/stderr | grep -x "TEST PASS" > /dev/null

clean:
	rm -rf obj_dir
